// File: dv/frontEndQueueCases.txt
// one cycle per line: ready_vector_stall_flush_expReady_expStallFetch_expBranch
// expBranch is checked only where expReady is 1.
// reset state, then gapped groups flowing straight through.
1_a5_0_0_0_0_0
1_3c_0_0_1_0_1
1_81_0_0_1_0_1
// back end stalls, queue fills past 24 and fetch stalls.
1_ff_1_0_0_0_0
1_ff_1_0_1_0_2
1_7f_1_0_1_0_2
1_ff_1_0_1_1_2
1_0f_1_0_1_1_2
// stall released.
0_00_0_0_1_1_2
1_f0_0_0_1_0_1
1_55_0_0_1_0_1
// misprediction flush, group of this cycle is lost.
1_ff_0_1_1_0_2
1_0e_0_0_0_0_0
1_09_0_0_0_0_0
// full groups with dispatch every cycle, pointers wrap.
1_ff_0_0_1_0_1
1_ff_0_0_1_0_2
1_ff_0_0_1_0_1
1_ff_0_0_1_0_1
1_ff_0_0_1_0_2
1_ff_0_0_1_1_1
1_0f_0_0_1_0_1
0_00_0_0_1_0_2
0_00_0_0_1_0_1

// File: dv/frontEndQueueTb.sv
/*
  Self-checking testbench for the decode-to-dispatch queue.
  Replays dv/frontEndQueueCases.txt one cycle per line, keeps a packet
  queue model of the buffer, then drains what is left at the end.
*/
`timescale 1ns/1ns
`default_nettype none

`include "frontEnd_params.svh"

module frontEndQueueTb;

  logic                     clk;
  logic                     reset_i;
  logic                     flush_i;
  logic                     stall_i;
  logic                     decodeReady_i;
  frontEndPkg::laneVecT     decodedVector_i;
  frontEndPkg::packetT      lanePkt [`FETCH_WIDTH];     // decode lanes as driven.
  logic                     stallFetch_o;
  logic                     instBufferReady_o;
  frontEndPkg::packetT      dispatchPkt [`DISPATCH_WIDTH];
  frontEndPkg::branchCountT branchCount_o;

  logic [31:0]         caseMem [64];                    // one word per cycle.
  frontEndPkg::packetT model [$];                       // packets waiting with the head first.
  logic [31:0]         lcgState;
  int                  genIndex;                        // packets generated so far.
  int                  caseIdx;
  int                  guard;

  frontEndQueue UUT (
    .clk              (clk),
    .reset_i          (reset_i),
    .flush_i          (flush_i),
    .stall_i          (stall_i),
    .decodeReady_i    (decodeReady_i),
    .decodedVector_i  (decodedVector_i),
    .decodedPacket0_i (lanePkt[0]),
    .decodedPacket1_i (lanePkt[1]),
    .decodedPacket2_i (lanePkt[2]),
    .decodedPacket3_i (lanePkt[3]),
    .decodedPacket4_i (lanePkt[4]),
    .decodedPacket5_i (lanePkt[5]),
    .decodedPacket6_i (lanePkt[6]),
    .decodedPacket7_i (lanePkt[7]),
    .stallFetch_o     (stallFetch_o),
    .instBufferReady_o(instBufferReady_o),
    .decodedPacket0_o (dispatchPkt[0]),
    .decodedPacket1_o (dispatchPkt[1]),
    .decodedPacket2_o (dispatchPkt[2]),
    .decodedPacket3_o (dispatchPkt[3]),
    .branchCount_o    (branchCount_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                              // 8 ns period.
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;              // 32-bit linear congruential step.
  endfunction

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first failure.");
  endtask

  task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      failRun($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  // word layout is ready, vector, stall, flush, exp ready, exp stall fetch, exp branches.
  task automatic driveCycle(input logic [31:0] word);
    decodeReady_i   = word[28];
    decodedVector_i = word[27:20];
    stall_i         = word[16];
    flush_i         = word[12];
    for (int l = 0; l < `FETCH_WIDTH; l++) begin
      if (word[28] && word[20+l]) begin
        lcgState   = lcgNext(lcgState);
        lanePkt[l] = {(genIndex % 3 == 2), lcgState[`BRANCH_BIT-1:0]}; // every third a branch.
        genIndex++;
      end else begin
        lanePkt[l] = 32'h0bad_0000 | 32'(l);            // junk lane that is never dispatched.
      end
    end
  endtask

  task automatic checkOutputs(input logic [31:0] word, input logic useFile);
    int branches;
    branches = 0;
    checkValue(32'(instBufferReady_o), 32'(model.size() >= `DISPATCH_WIDTH),
               "instBufferReady_o vs model");
    checkValue(32'(stallFetch_o), 32'(model.size() > `INST_QUEUE - `FETCH_WIDTH),
               "stallFetch_o vs model");
    if (useFile) begin
      checkValue(32'(instBufferReady_o), 32'(word[8]), "instBufferReady_o");
      checkValue(32'(stallFetch_o), 32'(word[4]), "stallFetch_o");
      if (word[8]) begin
        checkValue(32'(branchCount_o), 32'(word[2:0]), "branchCount_o");
      end
    end
    if (model.size() >= `DISPATCH_WIDTH) begin
      for (int d = 0; d < `DISPATCH_WIDTH; d++) begin
        checkValue(dispatchPkt[d], model[d], $sformatf("decodedPacket%0d_o", d));
        if (model[d][`BRANCH_BIT]) begin
          branches++;
        end
      end
      checkValue(32'(branchCount_o), 32'(branches), "branchCount_o vs model");
    end
  endtask

  // called right after the edge while the inputs still hold the values of the cycle.
  task automatic updateModel();
    logic accept;
    accept = decodeReady_i && (model.size() <= `INST_QUEUE - `FETCH_WIDTH);
    if (flush_i) begin
      model.delete();                                   // flush wins over read and write.
    end else begin
      if (model.size() >= `DISPATCH_WIDTH && !stall_i) begin
        for (int d = 0; d < `DISPATCH_WIDTH; d++) begin
          model.delete(0);
        end
      end
      if (accept) begin
        for (int l = 0; l < `FETCH_WIDTH; l++) begin
          if (decodedVector_i[l]) begin
            model.push_back(lanePkt[l]);                // ascending lane order.
          end
        end
      end
    end
  endtask

  initial begin
    reset_i         = 1'b1;
    flush_i         = 1'b0;
    stall_i         = 1'b0;
    decodeReady_i   = 1'b0;
    decodedVector_i = '0;
    for (int l = 0; l < `FETCH_WIDTH; l++) begin
      lanePkt[l] = '0;
    end
    lcgState = 32'd17999;
    genIndex = 0;
    for (int i = 0; i < 64; i++) begin
      caseMem[i] = {16'hffff, 16'(i)};                  // ready nibble f marks the end.
    end
    $readmemh("dv/frontEndQueueCases.txt", caseMem);
    if (caseMem[0][31:28] == 4'hf) begin
      failRun("cases file is missing or holds no cases");
    end
    repeat (8) @(posedge clk);
    #1 reset_i = 1'b0;
    caseIdx = 0;
    while (caseIdx < 64 && caseMem[caseIdx][31:28] != 4'hf) begin
      driveCycle(caseMem[caseIdx]);
      #3;
      checkOutputs(caseMem[caseIdx], 1'b1);             // mid-cycle where state is stable.
      @(posedge clk);
      updateModel();
      #1;
      caseIdx++;
    end
    // drain the remaining windows with decode idle.
    decodeReady_i   = 1'b0;
    decodedVector_i = '0;
    stall_i         = 1'b0;
    flush_i         = 1'b0;
    guard           = 0;
    #3;
    while (instBufferReady_o) begin
      if (guard == 16) begin
        failRun("timeout while waiting for the queue to drain");
      end
      checkOutputs(32'h0, 1'b0);
      @(posedge clk);
      updateModel();
      #4;
      guard++;
    end
    checkOutputs(32'h0, 1'b0);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/decodeCompactor.sv
/*
  Packs the valid lanes of a decode group down to lane 0 and counts them.
  Purely combinational, sits between decode and the instruction buffer.
*/
`timescale 1ns/1ns
`default_nettype none

`include "frontEnd_params.svh"

module decodeCompactor (
  input  wire frontEndPkg::laneVecT decodedVector_i,
  input  wire frontEndPkg::packetT  decodedPacket0_i,
  input  wire frontEndPkg::packetT  decodedPacket1_i,
  input  wire frontEndPkg::packetT  decodedPacket2_i,
  input  wire frontEndPkg::packetT  decodedPacket3_i,
  input  wire frontEndPkg::packetT  decodedPacket4_i,
  input  wire frontEndPkg::packetT  decodedPacket5_i,
  input  wire frontEndPkg::packetT  decodedPacket6_i,
  input  wire frontEndPkg::packetT  decodedPacket7_i,
  output frontEndPkg::packetT       packedPacket0_o,
  output frontEndPkg::packetT       packedPacket1_o,
  output frontEndPkg::packetT       packedPacket2_o,
  output frontEndPkg::packetT       packedPacket3_o,
  output frontEndPkg::packetT       packedPacket4_o,
  output frontEndPkg::packetT       packedPacket5_o,
  output frontEndPkg::packetT       packedPacket6_o,
  output frontEndPkg::packetT       packedPacket7_o,
  output frontEndPkg::laneCountT    packedCount_o
);

  frontEndPkg::packetT    laneIn [`FETCH_WIDTH];     // decode lanes, gaps allowed.
  frontEndPkg::packetT    laneOut [`FETCH_WIDTH];    // packed lanes.
  frontEndPkg::laneCountT slot;                      // valid lanes below the current one.

  assign laneIn = '{decodedPacket0_i, decodedPacket1_i, decodedPacket2_i, decodedPacket3_i,
                    decodedPacket4_i, decodedPacket5_i, decodedPacket6_i, decodedPacket7_i};

  // each valid lane lands at the count of valid lanes beneath it,
  // so ascending lane order is kept.
  always_comb begin
    slot = '0;
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      laneOut[k] = '0;                               // unused positions read as zero.
    end
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      if (decodedVector_i[i]) begin
        laneOut[slot[$clog2(`FETCH_WIDTH)-1:0]] = laneIn[i]; // slot never exceeds i here.
        slot = slot + 1'b1;
      end
    end
    if (!$isunknown(decodedVector_i)) begin
      // the running count must agree with a plain popcount of the vector.
      assert (slot == frontEndPkg::laneCountT'($countones(decodedVector_i)))
        else $error("decodeCompactor: packed count disagrees with valid vector.");
    end
  end

  assign packedPacket0_o = laneOut[0];
  assign packedPacket1_o = laneOut[1];
  assign packedPacket2_o = laneOut[2];
  assign packedPacket3_o = laneOut[3];
  assign packedPacket4_o = laneOut[4];
  assign packedPacket5_o = laneOut[5];
  assign packedPacket6_o = laneOut[6];
  assign packedPacket7_o = laneOut[7];
  assign packedCount_o   = slot;                     // total valid lanes.

endmodule

`default_nettype wire

// File: hw/frontEndPkg.sv
/*
  Types shared by the decode-to-dispatch queue.
  Referenced by scoped name from every RTL file and the testbench.
*/
`default_nettype none

`include "frontEnd_params.svh"

package frontEndPkg;

  // one decoded instruction, bit BRANCH_BIT flags a branch.
  typedef logic [`PACKET_W-1:0] packetT;

  // slot index into the circular packet memory.
  typedef logic [`INST_QUEUE_LOG-1:0] queuePtrT;

  // occupancy, one bit wider so a full queue is representable.
  typedef logic [`INST_QUEUE_LOG:0] queueCountT;

  // per-lane valid bits of a decode group.
  typedef logic [`FETCH_WIDTH-1:0] laneVecT;

  // number of valid lanes, 0 up to FETCH_WIDTH inclusive.
  typedef logic [$clog2(`FETCH_WIDTH+1)-1:0] laneCountT;

  // branches seen in the dispatch window.
  typedef logic [`BRANCH_COUNT_W-1:0] branchCountT;

endpackage

`default_nettype wire

// File: hw/frontEndQueue.sv
/*
  Decode-to-dispatch queue top level.
  Compacts each decode group, then buffers it for four-wide dispatch.
*/
`timescale 1ns/1ns
`default_nettype none

`include "frontEnd_params.svh"

module frontEndQueue (
  input  wire logic                 clk,
  input  wire logic                 reset_i,
  input  wire logic                 flush_i,            // control misprediction.
  input  wire logic                 stall_i,            // back end cannot take a window.
  input  wire logic                 decodeReady_i,
  input  wire frontEndPkg::laneVecT decodedVector_i,
  input  wire frontEndPkg::packetT  decodedPacket0_i,
  input  wire frontEndPkg::packetT  decodedPacket1_i,
  input  wire frontEndPkg::packetT  decodedPacket2_i,
  input  wire frontEndPkg::packetT  decodedPacket3_i,
  input  wire frontEndPkg::packetT  decodedPacket4_i,
  input  wire frontEndPkg::packetT  decodedPacket5_i,
  input  wire frontEndPkg::packetT  decodedPacket6_i,
  input  wire frontEndPkg::packetT  decodedPacket7_i,
  output logic                      stallFetch_o,       // hold the decode group.
  output logic                      instBufferReady_o,  // window valid.
  output frontEndPkg::packetT       decodedPacket0_o,
  output frontEndPkg::packetT       decodedPacket1_o,
  output frontEndPkg::packetT       decodedPacket2_o,
  output frontEndPkg::packetT       decodedPacket3_o,
  output frontEndPkg::branchCountT  branchCount_o
);

  frontEndPkg::packetT    packedPacket [`FETCH_WIDTH]; // compacted group.
  frontEndPkg::laneCountT packedCount;

  decodeCompactor compactor (
    .decodedVector_i (decodedVector_i),
    .decodedPacket0_i(decodedPacket0_i),
    .decodedPacket1_i(decodedPacket1_i),
    .decodedPacket2_i(decodedPacket2_i),
    .decodedPacket3_i(decodedPacket3_i),
    .decodedPacket4_i(decodedPacket4_i),
    .decodedPacket5_i(decodedPacket5_i),
    .decodedPacket6_i(decodedPacket6_i),
    .decodedPacket7_i(decodedPacket7_i),
    .packedPacket0_o (packedPacket[0]),
    .packedPacket1_o (packedPacket[1]),
    .packedPacket2_o (packedPacket[2]),
    .packedPacket3_o (packedPacket[3]),
    .packedPacket4_o (packedPacket[4]),
    .packedPacket5_o (packedPacket[5]),
    .packedPacket6_o (packedPacket[6]),
    .packedPacket7_o (packedPacket[7]),
    .packedCount_o   (packedCount)
  );

  instBuffer buffer (
    .clk              (clk),
    .reset_i          (reset_i),
    .flush_i          (flush_i),
    .stall_i          (stall_i),
    .decodeReady_i    (decodeReady_i),
    .packedCount_i    (packedCount),
    .packedPacket0_i  (packedPacket[0]),
    .packedPacket1_i  (packedPacket[1]),
    .packedPacket2_i  (packedPacket[2]),
    .packedPacket3_i  (packedPacket[3]),
    .packedPacket4_i  (packedPacket[4]),
    .packedPacket5_i  (packedPacket[5]),
    .packedPacket6_i  (packedPacket[6]),
    .packedPacket7_i  (packedPacket[7]),
    .stallFetch_o     (stallFetch_o),
    .instBufferReady_o(instBufferReady_o),
    .decodedPacket0_o (decodedPacket0_o),
    .decodedPacket1_o (decodedPacket1_o),
    .decodedPacket2_o (decodedPacket2_o),
    .decodedPacket3_o (decodedPacket3_o),
    .branchCount_o    (branchCount_o)
  );

endmodule

`default_nettype wire

// File: hw/instBuffer.sv
/*
  Instruction buffer between decode and dispatch.
  Takes packed decode groups at the tail, offers four-packet windows at the
  head, raises fetch stall when a full group may not fit. Flush empties it.
*/
`timescale 1ns/1ns
`default_nettype none

`include "frontEnd_params.svh"

module instBuffer (
  input  wire logic                   clk,
  input  wire logic                   reset_i,
  input  wire logic                   flush_i,
  input  wire logic                   stall_i,
  input  wire logic                   decodeReady_i,
  input  wire frontEndPkg::laneCountT packedCount_i,
  input  wire frontEndPkg::packetT    packedPacket0_i,
  input  wire frontEndPkg::packetT    packedPacket1_i,
  input  wire frontEndPkg::packetT    packedPacket2_i,
  input  wire frontEndPkg::packetT    packedPacket3_i,
  input  wire frontEndPkg::packetT    packedPacket4_i,
  input  wire frontEndPkg::packetT    packedPacket5_i,
  input  wire frontEndPkg::packetT    packedPacket6_i,
  input  wire frontEndPkg::packetT    packedPacket7_i,
  output logic                        stallFetch_o,
  output logic                        instBufferReady_o,
  output frontEndPkg::packetT         decodedPacket0_o,
  output frontEndPkg::packetT         decodedPacket1_o,
  output frontEndPkg::packetT         decodedPacket2_o,
  output frontEndPkg::packetT         decodedPacket3_o,
  output frontEndPkg::branchCountT    branchCount_o
);

  frontEndPkg::queuePtrT   headPtr;                    // oldest waiting packet.
  frontEndPkg::queuePtrT   tailPtr;                    // next free slot.
  frontEndPkg::queueCountT instCount;                  // packets waiting.
  frontEndPkg::queueCountT instCountNext;
  logic                    groupAccept;                // decode group written this cycle.
  logic                    windowTake;                 // dispatch window consumed this cycle.
  logic [`FETCH_WIDTH-1:0] writeEnable;                // one per packed lane.
  frontEndPkg::queuePtrT   writeAddr [`FETCH_WIDTH];
  frontEndPkg::queuePtrT   readAddr [`DISPATCH_WIDTH];

  // status straight from the occupancy register.
  assign instBufferReady_o = (instCount >= frontEndPkg::queueCountT'(`DISPATCH_WIDTH));
  assign stallFetch_o = (instCount > frontEndPkg::queueCountT'(`INST_QUEUE - `FETCH_WIDTH));

  assign groupAccept = decodeReady_i && !stallFetch_o && !flush_i; // flush drops the group.
  assign windowTake  = instBufferReady_o && !stall_i && !flush_i;

  always_comb begin
    for (int p = 0; p < `FETCH_WIDTH; p++) begin
      writeAddr[p]   = tailPtr + frontEndPkg::queuePtrT'(p);  // wraps at the depth.
      writeEnable[p] = groupAccept && (frontEndPkg::laneCountT'(p) < packedCount_i);
    end
    for (int r = 0; r < `DISPATCH_WIDTH; r++) begin
      readAddr[r] = headPtr + frontEndPkg::queuePtrT'(r);     // window starts at the head.
    end
  end

  packetRam ram (
    .clk           (clk),
    .reset_i       (reset_i),
    .readAddr0_i   (readAddr[0]),
    .readAddr1_i   (readAddr[1]),
    .readAddr2_i   (readAddr[2]),
    .readAddr3_i   (readAddr[3]),
    .writeEnable0_i(writeEnable[0]),
    .writeEnable1_i(writeEnable[1]),
    .writeEnable2_i(writeEnable[2]),
    .writeEnable3_i(writeEnable[3]),
    .writeEnable4_i(writeEnable[4]),
    .writeEnable5_i(writeEnable[5]),
    .writeEnable6_i(writeEnable[6]),
    .writeEnable7_i(writeEnable[7]),
    .writeAddr0_i  (writeAddr[0]),
    .writeAddr1_i  (writeAddr[1]),
    .writeAddr2_i  (writeAddr[2]),
    .writeAddr3_i  (writeAddr[3]),
    .writeAddr4_i  (writeAddr[4]),
    .writeAddr5_i  (writeAddr[5]),
    .writeAddr6_i  (writeAddr[6]),
    .writeAddr7_i  (writeAddr[7]),
    .writeData0_i  (packedPacket0_i),
    .writeData1_i  (packedPacket1_i),
    .writeData2_i  (packedPacket2_i),
    .writeData3_i  (packedPacket3_i),
    .writeData4_i  (packedPacket4_i),
    .writeData5_i  (packedPacket5_i),
    .writeData6_i  (packedPacket6_i),
    .writeData7_i  (packedPacket7_i),
    .readData0_o   (decodedPacket0_o),
    .readData1_o   (decodedPacket1_o),
    .readData2_o   (decodedPacket2_o),
    .readData3_o   (decodedPacket3_o)
  );

  // branch flags of the four packets on display.
  assign branchCount_o = frontEndPkg::branchCountT'(decodedPacket0_o[`BRANCH_BIT])
                       + frontEndPkg::branchCountT'(decodedPacket1_o[`BRANCH_BIT])
                       + frontEndPkg::branchCountT'(decodedPacket2_o[`BRANCH_BIT])
                       + frontEndPkg::branchCountT'(decodedPacket3_o[`BRANCH_BIT]);

  always_comb begin
    instCountNext = instCount;
    if (groupAccept) begin
      instCountNext = instCountNext + frontEndPkg::queueCountT'(packedCount_i);
    end
    if (windowTake) begin
      instCountNext = instCountNext - frontEndPkg::queueCountT'(`DISPATCH_WIDTH);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      headPtr   <= '0;                                 // flush behaves like reset here.
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      if (groupAccept) begin
        tailPtr <= tailPtr + frontEndPkg::queuePtrT'(packedCount_i);
      end
      if (windowTake) begin
        headPtr <= headPtr + frontEndPkg::queuePtrT'(`DISPATCH_WIDTH);
      end
      instCount <= instCountNext;
    end
  end

  // stall threshold plus one full group must still fit.
  assert property (@(posedge clk) disable iff (reset_i)
    instCount <= frontEndPkg::queueCountT'(`INST_QUEUE))
    else $error("instBuffer: occupancy above queue depth.");

  // a stalled fetch cycle leaves the tail where it was.
  assert property (@(posedge clk) disable iff (reset_i)
    (stallFetch_o && !flush_i) |=> $stable(tailPtr))
    else $error("instBuffer: tail moved while fetch was stalled.");

endmodule

`default_nettype wire

// File: hw/packetRam.sv
/*
  Circular packet memory of the instruction queue.
  Eight enabled write ports commit at the clock edge, four read ports are
  combinational. Enabled write addresses in one cycle must be distinct.
*/
`timescale 1ns/1ns
`default_nettype none

`include "frontEnd_params.svh"

module packetRam (
  input  wire logic                clk,
  input  wire logic                reset_i,
  input  wire frontEndPkg::queuePtrT readAddr0_i,
  input  wire frontEndPkg::queuePtrT readAddr1_i,
  input  wire frontEndPkg::queuePtrT readAddr2_i,
  input  wire frontEndPkg::queuePtrT readAddr3_i,
  input  wire logic                writeEnable0_i,
  input  wire logic                writeEnable1_i,
  input  wire logic                writeEnable2_i,
  input  wire logic                writeEnable3_i,
  input  wire logic                writeEnable4_i,
  input  wire logic                writeEnable5_i,
  input  wire logic                writeEnable6_i,
  input  wire logic                writeEnable7_i,
  input  wire frontEndPkg::queuePtrT writeAddr0_i,
  input  wire frontEndPkg::queuePtrT writeAddr1_i,
  input  wire frontEndPkg::queuePtrT writeAddr2_i,
  input  wire frontEndPkg::queuePtrT writeAddr3_i,
  input  wire frontEndPkg::queuePtrT writeAddr4_i,
  input  wire frontEndPkg::queuePtrT writeAddr5_i,
  input  wire frontEndPkg::queuePtrT writeAddr6_i,
  input  wire frontEndPkg::queuePtrT writeAddr7_i,
  input  wire frontEndPkg::packetT   writeData0_i,
  input  wire frontEndPkg::packetT   writeData1_i,
  input  wire frontEndPkg::packetT   writeData2_i,
  input  wire frontEndPkg::packetT   writeData3_i,
  input  wire frontEndPkg::packetT   writeData4_i,
  input  wire frontEndPkg::packetT   writeData5_i,
  input  wire frontEndPkg::packetT   writeData6_i,
  input  wire frontEndPkg::packetT   writeData7_i,
  output frontEndPkg::packetT        readData0_o,
  output frontEndPkg::packetT        readData1_o,
  output frontEndPkg::packetT        readData2_o,
  output frontEndPkg::packetT        readData3_o
);

  frontEndPkg::packetT   mem [`INST_QUEUE];          // packet slots.
  logic [`FETCH_WIDTH-1:0] writeEnable;              // port enables, lane 0 in bit 0.
  frontEndPkg::queuePtrT writeAddr [`FETCH_WIDTH];   // per-port slot.
  frontEndPkg::packetT   writeData [`FETCH_WIDTH];   // per-port payload.
  logic                  writeClash;                 // two ports aimed at one slot.

  assign writeEnable = {writeEnable7_i, writeEnable6_i, writeEnable5_i, writeEnable4_i,
                        writeEnable3_i, writeEnable2_i, writeEnable1_i, writeEnable0_i};
  assign writeAddr = '{writeAddr0_i, writeAddr1_i, writeAddr2_i, writeAddr3_i,
                       writeAddr4_i, writeAddr5_i, writeAddr6_i, writeAddr7_i};
  assign writeData = '{writeData0_i, writeData1_i, writeData2_i, writeData3_i,
                       writeData4_i, writeData5_i, writeData6_i, writeData7_i};

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int e = 0; e < `INST_QUEUE; e++) begin
        mem[e] <= '0;                                // defined read data before first write.
      end
    end else begin
      for (int p = 0; p < `FETCH_WIDTH; p++) begin
        if (writeEnable[p]) begin
          mem[writeAddr[p]] <= writeData[p];         // ports are independent.
        end
      end
    end
  end

  // dispatch sees the slots without a cycle of latency.
  assign readData0_o = mem[readAddr0_i];
  assign readData1_o = mem[readAddr1_i];
  assign readData2_o = mem[readAddr2_i];
  assign readData3_o = mem[readAddr3_i];

  always_comb begin
    writeClash = 1'b0;
    for (int a = 0; a < `FETCH_WIDTH; a++) begin
      for (int b = a + 1; b < `FETCH_WIDTH; b++) begin
        if (writeEnable[a] && writeEnable[b] && (writeAddr[a] == writeAddr[b])) begin
          writeClash = 1'b1;                         // pairwise compare of enabled ports.
        end
      end
    end
  end

  // the buffer must never hand two lanes the same slot in one cycle.
  assert property (@(posedge clk) disable iff (reset_i) !writeClash)
    else $error("packetRam: two write ports target one slot.");

endmodule

`default_nettype wire

// File: include/frontEnd_params.svh
/*
  Widths and depths of the decode-to-dispatch queue.
  Included by every RTL file and by the testbench.
*/
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// decode side.
`define FETCH_WIDTH 8              // lanes in one decode group.

// dispatch side.
`define DISPATCH_WIDTH 4           // packets offered per dispatch window.

// circular packet memory.
`define INST_QUEUE 32              // slots, must stay a power of two.
`define INST_QUEUE_LOG 5           // slot index width, log2 of the depth.

// decoded instruction packet.
`define PACKET_W 32                // full packet width in bits.
`define BRANCH_BIT 31              // control-transfer flag inside a packet.

// branch count over one dispatch window, 0 to 4.
`define BRANCH_COUNT_W 3

`endif

// File: runSim.sh
#!/usr/bin/env bash
# Builds the frontEndQueue testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
  --top-module frontEndQueueTb -o frontEndQueueSim -f verilog.f

# the simulator status is ignored here, the log decides.
./obj_dir/frontEndQueueSim 2>&1 | tee sim.log

if grep -q 'Test failures found' sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if ! grep -q 'All tests passed!' sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
echo "simulation PASSED"

// File: verilog.f
+incdir+include
hw/frontEndPkg.sv
hw/packetRam.sv
hw/decodeCompactor.sv
hw/instBuffer.sv
hw/frontEndQueue.sv
dv/frontEndQueueTb.sv
